//--- rtl/cpu_cfg.svh
// Execute slice configuration
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Register and bus data width
`define CPU_DATA_WIDTH 16

// Register file depth
`define CPU_REG_COUNT 16

// Register index width
`define CPU_REG_IDX_WIDTH $clog2(`CPU_REG_COUNT)

`endif

//--- rtl/cpu_pkg.sv
// Execute slice types
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_NAND = 4'd2,
		OP_XOR  = 4'd3,
		OP_INC  = 4'd4,
		OP_SRA  = 4'd5,
		OP_SRL  = 4'd6,
		OP_SLL  = 4'd7,
		OP_LW   = 4'd8,
		OP_SW   = 4'd9,
		OP_LHB  = 4'd10,
		OP_LLB  = 4'd11,
		OP_B    = 4'd12,
		OP_CALL = 4'd13,
		OP_RET  = 4'd14,
		OP_ERR  = 4'd15
	} opcode_e;

	// Same encoding as the low opcode bits of the arithmetic group
	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SUB  = 3'd1,
		ALU_NAND = 3'd2,
		ALU_XOR  = 3'd3,
		ALU_INC  = 3'd4,
		ALU_SRA  = 3'd5,
		ALU_SRL  = 3'd6,
		ALU_SLL  = 3'd7
	} alu_op_e;

	typedef struct packed {
		opcode_e                          opcode;
		logic [`CPU_REG_IDX_WIDTH-1:0] rd;
		logic [`CPU_REG_IDX_WIDTH-1:0] rs;
		logic [`CPU_REG_IDX_WIDTH-1:0] rt; // Also the INC immediate
	} instr_t;

	typedef struct packed {
		logic    reg_write;
		alu_op_e alu_op;
		logic    alu_src;    // Immediate as operand B
		logic    rt_from_rd; // Port 2 reads rd
		logic    load_half;
		logic    half_high;  // LHB when set
	} ctrl_t;

	typedef struct packed {
		logic                       cyc;
		logic                       stb;
		logic                       we;
		logic [4:0]                 adr;
		logic [`CPU_DATA_WIDTH-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic                       ack;
		logic                       err;
		logic [`CPU_DATA_WIDTH-1:0] dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

//--- rtl/control_decoder.sv
// Opcode control decoder
`default_nettype none

module control_decoder (
	input  cpu_pkg::opcode_e opcode,
	output cpu_pkg::ctrl_t   ctrl,
	output logic             illegal
);

	import cpu_pkg::*;

	always_comb begin
		ctrl    = '0;
		illegal = 1'b0;

		case (opcode)
			// Register-register arithmetic and shifts
			OP_ADD,
			OP_SUB,
			OP_NAND,
			OP_XOR,
			OP_SRA,
			OP_SRL,
			OP_SLL: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op    = alu_op_e'(opcode[2:0]);
			end

			OP_INC: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op    = ALU_INC;
				ctrl.alu_src   = 1'b1; // 4-bit immediate in rt
			end

			// Half loads merge into the old rd value
			OP_LHB: begin
				ctrl.reg_write  = 1'b1;
				ctrl.rt_from_rd = 1'b1;
				ctrl.load_half  = 1'b1;
				ctrl.half_high  = 1'b1;
			end

			OP_LLB: begin
				ctrl.reg_write  = 1'b1;
				ctrl.rt_from_rd = 1'b1;
				ctrl.load_half  = 1'b1;
			end

			// No memory, stack or branch unit in this slice
			OP_LW,
			OP_SW,
			OP_B,
			OP_CALL,
			OP_RET,
			OP_ERR: begin
				illegal = 1'b1;
			end

			default: begin
				illegal = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/register_file.sv
// Sixteen-entry register file
`default_nettype none

`include "cpu_cfg.svh"

module register_file (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [`CPU_REG_IDX_WIDTH-1:0] rs_idx,
	input  logic [`CPU_REG_IDX_WIDTH-1:0] rt_idx,
	input  logic [`CPU_REG_IDX_WIDTH-1:0] wr_idx,
	input  logic [`CPU_REG_IDX_WIDTH-1:0] rd_idx,
	input  logic                          wr_en,
	input  logic [`CPU_DATA_WIDTH-1:0]    wr_data,
	output logic [`CPU_DATA_WIDTH-1:0]    rs_data,
	output logic [`CPU_DATA_WIDTH-1:0]    rt_data,
	output logic [`CPU_DATA_WIDTH-1:0]    rd_data
);

	logic [`CPU_DATA_WIDTH-1:0] regs [`CPU_REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Instruction operands
	assign rs_data = regs[rs_idx];
	assign rt_data = regs[rt_idx];

	assign rd_data = regs[rd_idx]; // Bus read port

endmodule

`default_nettype wire

//--- rtl/alu_writeback.sv
// ALU and half-load writeback
`default_nettype none

`include "cpu_cfg.svh"

module alu_writeback (
	input  cpu_pkg::ctrl_t                ctrl,
	input  cpu_pkg::instr_t               instr,
	input  logic [`CPU_DATA_WIDTH-1:0]    rs_data,
	input  logic [`CPU_DATA_WIDTH-1:0]    rt_data,
	output logic [`CPU_DATA_WIDTH-1:0]    result
);

	import cpu_pkg::*;

	logic [`CPU_DATA_WIDTH-1:0] operand_b;
	logic [`CPU_DATA_WIDTH-1:0] alu_result;
	logic [3:0]                 shamt;
	logic [7:0]                 imm_byte;

	// Zero-extended rt field for INC
	assign operand_b = ctrl.alu_src ?
		{{(`CPU_DATA_WIDTH - `CPU_REG_IDX_WIDTH){1'b0}}, instr.rt} : rt_data;

	assign shamt    = operand_b[3:0];
	assign imm_byte = {instr.rs, instr.rt}; // Low instruction byte

	always_comb begin
		case (ctrl.alu_op)
			ALU_ADD,
			ALU_INC:  alu_result = rs_data + operand_b;
			ALU_SUB:  alu_result = rs_data - operand_b;
			ALU_NAND: alu_result = ~(rs_data & operand_b);
			ALU_XOR:  alu_result = rs_data ^ operand_b;
			ALU_SRA:  alu_result = $signed(rs_data) >>> shamt;
			ALU_SRL:  alu_result = rs_data >> shamt;
			ALU_SLL:  alu_result = rs_data << shamt;
			default:  alu_result = '0;
		endcase
	end

	// Old rd value arrives on rt_data for the half loads
	always_comb begin
		if (ctrl.load_half) begin
			if (ctrl.half_high) begin
				result = {imm_byte, rt_data[7:0]};
			end else begin
				result = {rt_data[`CPU_DATA_WIDTH-1:8], imm_byte};
			end
		end else begin
			result = alu_result;
		end
	end

endmodule

`default_nettype wire

//--- rtl/wb_exec_port.sv
// Wishbone instruction and register port
`default_nettype none

`include "cpu_cfg.svh"

module wb_exec_port (
	input  logic                          clk,
	input  logic                          reset,
	input  cpu_pkg::wb_req_t              req,
	output cpu_pkg::wb_rsp_t              rsp,
	output cpu_pkg::instr_t               instr,
	input  cpu_pkg::ctrl_t                ctrl,
	input  logic                          illegal,
	output logic                          wr_en,
	input  logic [`CPU_DATA_WIDTH-1:0]    rd_data,
	output logic [`CPU_REG_IDX_WIDTH-1:0] rd_idx
);

	import cpu_pkg::*;

	logic pending;
	logic new_xfer;
	logic instr_sel;
	logic reject;

	// Response cycle blocks re-sampling of a held request
	assign pending   = rsp.ack | rsp.err;
	assign new_xfer  = req.cyc & req.stb & ~pending;
	assign instr_sel = ~req.adr[4];

	// Illegal opcode, or a read of the write-only instruction port
	assign reject = instr_sel & (illegal | ~req.we);

	assign instr  = instr_t'(req.dat);
	assign rd_idx = req.adr[`CPU_REG_IDX_WIDTH-1:0];

	assign wr_en = new_xfer & instr_sel & req.we & ~illegal & ctrl.reg_write;

	always_ff @(posedge clk) begin
		if (reset) begin
			rsp <= '0;
		end else begin
			rsp.ack <= new_xfer & ~reject;
			rsp.err <= new_xfer & reject;
			if (new_xfer && !instr_sel) begin
				rsp.dat <= rd_data; // Register read data
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/exec_core_top.sv
// Execute slice top level
`default_nettype none

`include "cpu_cfg.svh"

module exec_core_top (
	input  logic             clk,
	input  logic             reset,
	input  cpu_pkg::wb_req_t wb_req,
	output cpu_pkg::wb_rsp_t wb_rsp
);

	import cpu_pkg::*;

	instr_t                        instr;
	ctrl_t                         ctrl;
	logic                          illegal;
	logic                          wr_en;
	logic [`CPU_REG_IDX_WIDTH-1:0] rt_idx;
	logic [`CPU_REG_IDX_WIDTH-1:0] rd_idx;
	logic [`CPU_DATA_WIDTH-1:0]    rs_data;
	logic [`CPU_DATA_WIDTH-1:0]    rt_data;
	logic [`CPU_DATA_WIDTH-1:0]    rd_data;
	logic [`CPU_DATA_WIDTH-1:0]    result;

	assign rt_idx = ctrl.rt_from_rd ? instr.rd : instr.rt; // Half loads read rd

	wb_exec_port i_port (
		.clk     (clk),
		.reset   (reset),
		.req     (wb_req),
		.rsp     (wb_rsp),
		.instr   (instr),
		.ctrl    (ctrl),
		.illegal (illegal),
		.wr_en   (wr_en),
		.rd_data (rd_data),
		.rd_idx  (rd_idx)
	);

	control_decoder i_decoder (
		.opcode  (instr.opcode),
		.ctrl    (ctrl),
		.illegal (illegal)
	);

	register_file i_regfile (
		.clk     (clk),
		.reset   (reset),
		.rs_idx  (instr.rs),
		.rt_idx  (rt_idx),
		.wr_idx  (instr.rd),
		.rd_idx  (rd_idx),
		.wr_en   (wr_en),
		.wr_data (result),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.rd_data (rd_data)
	);

	alu_writeback i_alu (
		.ctrl    (ctrl),
		.instr   (instr),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.result  (result)
	);

endmodule

`default_nettype wire

//--- verif/exec_core_asserts.sv
// Bus protocol assertions
`default_nettype none

module exec_core_asserts (
	input logic             clk,
	input logic             reset,
	input cpu_pkg::wb_req_t wb_req,
	input cpu_pkg::wb_rsp_t wb_rsp
);

	import cpu_pkg::*;

	logic responding;

	assign responding = wb_rsp.ack | wb_rsp.err;

	ack_err_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(wb_rsp.ack && wb_rsp.err))
		else $error("ack and err high in the same cycle");

	single_cycle_rsp: assert property (@(posedge clk) disable iff (reset)
		responding |=> !responding)
		else $error("Response held for more than one cycle");

	rsp_after_request: assert property (@(posedge clk) disable iff (reset)
		responding |-> $past(wb_req.cyc && wb_req.stb))
		else $error("Response without an active bus cycle");

	// Response flags clear out of reset
	reset_clears_rsp: assert property (@(posedge clk) reset |=> !responding)
		else $error("Response not cleared by reset");

endmodule

`default_nettype wire

//--- verif/exec_core_tb.sv
// Execute slice testbench
`default_nettype none

`include "cpu_cfg.svh"

module exec_core_tb;

	import cpu_pkg::*;

	logic                       clk;
	logic                       reset;
	wb_req_t                    req;
	wb_rsp_t                    rsp;
	logic [31:0]                lfsr;
	logic [`CPU_DATA_WIDTH-1:0] reg_model [`CPU_REG_COUNT];
	opcode_e                    illegal_ops [6] = '{OP_LW, OP_SW, OP_B, OP_CALL, OP_RET, OP_ERR};

	exec_core_top i_dut (
		.clk    (clk),
		.reset  (reset),
		.wb_req (req),
		.wb_rsp (rsp)
	);

	bind exec_core_top exec_core_asserts i_asserts (
		.clk    (clk),
		.reset  (reset),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	always #20 clk = ~clk;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val  = {val[14:0], lfsr[0]};
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_rsp(input string name, input wb_rsp_t got, input wb_rsp_t exp);
		if ({got.ack, got.err} !== {exp.ack, exp.err}) begin
			report_failure($sformatf("FAIL time=%0t %s ack/err got=%b%b expected=%b%b",
				$time, name, got.ack, got.err, exp.ack, exp.err));
		end
	endtask

	task automatic check_data(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("FAIL time=%0t %s got=%h expected=%h",
				$time, name, got, exp));
		end
	endtask

	// Reference result from the model state before the write
	function automatic logic [15:0] expected_result(input instr_t ins);
		logic [15:0] a;
		logic [15:0] b;
		logic [7:0]  imm;
		a   = reg_model[ins.rs];
		b   = reg_model[ins.rt];
		imm = {ins.rs, ins.rt};
		case (ins.opcode)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_NAND: return ~(a & b);
			OP_XOR:  return a ^ b;
			OP_INC:  return a + {12'd0, ins.rt};
			OP_SRA:  return $signed(a) >>> b[3:0];
			OP_SRL:  return a >> b[3:0];
			OP_SLL:  return a << b[3:0];
			OP_LHB:  return {imm, reg_model[ins.rd][7:0]};
			OP_LLB:  return {reg_model[ins.rd][15:8], imm};
			default: return '0;
		endcase
	endfunction

	// One transfer with latency and single-cycle response checks
	task automatic bus_xfer(input logic we, input logic [4:0] adr, input logic [15:0] dat,
		output wb_rsp_t got);
		int cycles;
		cycles = 0;
		@(posedge clk);
		req <= {1'b1, 1'b1, we, adr, dat};
		@(negedge clk);
		while (!(rsp.ack || rsp.err)) begin
			if (cycles == 20) begin
				report_failure("Timeout while waiting for a bus response");
			end
			@(negedge clk);
			cycles++;
		end
		got = rsp;
		if (cycles != 1) begin
			report_failure("Bus response did not arrive one cycle after the request");
		end
		@(posedge clk);
		req <= '0;
		@(negedge clk);
		check_rsp("wb_rsp_after", rsp, '0); // Response must drop
	endtask

	task automatic read_reg(input logic [3:0] idx, output logic [15:0] data);
		wb_rsp_t got;
		wb_rsp_t exp;
		exp     = '0;
		exp.ack = 1'b1;
		bus_xfer(1'b0, {1'b1, idx}, 16'h0, got);
		check_rsp("wb_rsp_read", got, exp);
		data = got.dat;
	endtask

	task automatic check_reg(input logic [3:0] idx);
		logic [15:0] data;
		read_reg(idx, data);
		check_data($sformatf("reg[%0d]", idx), data, reg_model[idx]);
	endtask

	task automatic check_all_regs();
		for (int i = 0; i < `CPU_REG_COUNT; i++) begin
			check_reg(4'(i));
		end
	endtask

	task automatic execute_instr(input instr_t ins);
		wb_rsp_t     got;
		wb_rsp_t     exp;
		logic        legal;
		logic [15:0] result;
		legal   = (ins.opcode inside {[OP_ADD:OP_SLL], OP_LHB, OP_LLB});
		result  = expected_result(ins);
		exp     = '0;
		exp.ack = legal;
		exp.err = !legal;
		bus_xfer(1'b1, 5'h00, ins, got);
		check_rsp("wb_rsp_instr", got, exp);
		if (legal) begin
			reg_model[ins.rd] = result;
		end
	endtask

	initial begin
		logic [15:0] bits;
		logic [15:0] lo;
		logic [15:0] hi;
		logic [15:0] rdata;
		wb_rsp_t     got;
		wb_rsp_t     exp;
		instr_t      ins;
		clk   = 1'b0;
		reset = 1'b1;
		req   = '0;
		lfsr  = 32'hccc5;
		for (int i = 0; i < `CPU_REG_COUNT; i++) begin
			reg_model[i] = '0;
		end
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		check_all_regs(); // All zero after reset

		// Half loads build full values in every register
		for (int i = 0; i < `CPU_REG_COUNT; i++) begin
			draw_bits(8, lo);
			draw_bits(8, hi);
			execute_instr({OP_LLB, 4'(i), lo[7:0]});
			execute_instr({OP_LHB, 4'(i), hi[7:0]});
			read_reg(4'(i), rdata);
			check_data("half_load", rdata, {hi[7:0], lo[7:0]});
		end

		for (int n = 0; n < 300; n++) begin
			draw_bits(3, bits);
			ins.opcode = opcode_e'({1'b0, bits[2:0]});
			draw_bits(12, bits);
			{ins.rd, ins.rs, ins.rt} = bits[11:0];
			execute_instr(ins);
			check_reg(ins.rd);
		end

		for (int n = 0; n < 24; n++) begin
			draw_bits(3, bits);
			ins.opcode = illegal_ops[bits[2:0] % 6];
			draw_bits(12, bits);
			{ins.rd, ins.rs, ins.rt} = bits[11:0];
			execute_instr(ins);
		end
		check_all_regs();

		// Writes into the register-read space change nothing
		exp     = '0;
		exp.ack = 1'b1;
		for (int n = 0; n < 8; n++) begin
			draw_bits(4, lo);
			draw_bits(16, hi);
			bus_xfer(1'b1, {1'b1, lo[3:0]}, hi, got);
			check_rsp("wb_rsp_reg_write", got, exp);
		end
		check_all_regs();

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/control_decoder.sv
rtl/register_file.sv
rtl/alu_writeback.sv
rtl/wb_exec_port.sv
rtl/exec_core_top.sv
verif/exec_core_asserts.sv
verif/exec_core_tb.sv

//--- Bender.yml
package:
  name: exec_core

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/cpu_pkg.sv
      - rtl/control_decoder.sv
      - rtl/register_file.sv
      - rtl/alu_writeback.sv
      - rtl/wb_exec_port.sv
      - rtl/exec_core_top.sv
  - target: test
    files:
      - verif/exec_core_asserts.sv
      - verif/exec_core_tb.sv
